/* src/rf_pkg.sv */
/*
 * Register file subsystem package
 * Geometry, APB register map, command codes and power sequencing depth
 */
package rf_pkg;

    // --------------------------------------------------
    // Array geometry
    // --------------------------------------------------
    localparam int RF_DEPTH   = 32;
    localparam int RF_ADDR_W  = 5;
    localparam int RF_DATA_W  = 56;
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;
    // Upper half of an entry as seen through the 32-bit bus
    localparam int HI_W       = RF_DATA_W - APB_DATA_W;

    // Number of flops in the power enable ripple chain
    localparam int PG_STAGES  = 4;

    // --------------------------------------------------
    // APB register offsets, word aligned
    // --------------------------------------------------
    localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_INDEX    = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_WDATA_LO = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_WDATA_HI = 8'h10;
    localparam logic [APB_ADDR_W-1:0] REG_CMD      = 8'h14;
    localparam logic [APB_ADDR_W-1:0] REG_RDATA_LO = 8'h18;
    localparam logic [APB_ADDR_W-1:0] REG_RDATA_HI = 8'h1C;

    // Codes written to REG_CMD
    localparam logic [APB_DATA_W-1:0] CMD_WRITE = 32'd1;
    localparam logic [APB_DATA_W-1:0] CMD_READ  = 32'd2;

    // Command FSM encodings
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WAIT1 = 2'd1;
    localparam logic [1:0] ST_WAIT2 = 2'd2;

endpackage

/* src/rf_array.sv */
`timescale 1ns/1ns
/*
 * 32x56 two-port register file array
 * Per-entry valid bits model retention loss, read port is registered
 */
module rf_array (
    input  logic                          clk,
    input  logic                          reset_sync,
    input  logic                          we,
    input  logic [rf_pkg::RF_ADDR_W-1:0]  waddr,
    input  logic [rf_pkg::RF_DATA_W-1:0]  wdata,
    input  logic                          re,
    input  logic [rf_pkg::RF_ADDR_W-1:0]  raddr,
    input  logic                          isol_en,
    input  logic                          pwr_enable_b,
    output logic [rf_pkg::RF_DATA_W-1:0]  rdata
);
    import rf_pkg::*;

    logic [RF_DATA_W-1:0] mem [RF_DEPTH];
    logic [RF_DEPTH-1:0]  valid;
    logic                 wr_ok;

    // Writes only land while the array is powered and not clamped
    assign wr_ok = we && !isol_en && !pwr_enable_b;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[waddr] <= wdata;
        end
    end

    // Valid bits stand in for the cell contents surviving a power cycle
    always_ff @(posedge clk) begin
        if (reset_sync) begin
            valid <= '0;
        end else if (pwr_enable_b) begin
            // Supply is off, so every entry is lost
            valid <= '0;
        end else if (wr_ok) begin
            valid[waddr] <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Registered read port
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_sync) begin
            rdata <= '0;
        end else if (re) begin
            // Unwritten or isolated entries read back as zero
            if (valid[raddr] && !isol_en) begin
                rdata <= mem[raddr];
            end else begin
                rdata <= '0;
            end
        end
    end

    // The controller and the wrapper gate together keep traffic off a clamped array
    assert property (@(posedge clk) disable iff (reset_sync)
        isol_en |-> !(we || re));

endmodule

/* src/rf_power_seq.sv */
`timescale 1ns/1ns
/*
 * Power gate sequencer for the register file
 * Ripples the enable through a flop chain, then releases isolation
 */
module rf_power_seq (
    input  logic clk,
    input  logic reset_sync,
    input  logic pwr_req,
    output logic pwr_enable_b,
    output logic isol_en,
    output logic pwr_good
);
    import rf_pkg::*;

    // Active low enable, one flop per power switch segment
    logic [PG_STAGES-1:0] en_b_chain;
    logic                 isol_q;

    // --------------------------------------------------
    // Enable ripple chain
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_sync || !pwr_req) begin
            // Dropping the request turns every segment off at once
            en_b_chain <= '1;
        end else begin
            en_b_chain <= {en_b_chain[PG_STAGES-2:0], 1'b0};
        end
    end

    // Isolation lifts one cycle after the last segment turns on
    always_ff @(posedge clk) begin
        if (reset_sync || !pwr_req) begin
            isol_q <= 1'b1;
        end else begin
            isol_q <= en_b_chain[PG_STAGES-1];
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    // Power-down bypasses the chain so the array sees it in the same cycle
    assign pwr_enable_b = en_b_chain[PG_STAGES-1] | ~pwr_req;
    assign isol_en      = isol_q | ~pwr_req;
    assign pwr_good     = ~isol_en & ~pwr_enable_b;

    // Power-good only once every switch segment in the chain is on
    assert property (@(posedge clk) disable iff (reset_sync)
        pwr_good |-> (en_b_chain == '0));

endmodule

/* src/rf_pg_wrapper.sv */
`timescale 1ns/1ns
/*
 * Power-gated register file wrapper
 * Synchronizes reset and places the array behind the power sequencer
 */
module rf_pg_wrapper (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          pwr_req,
    input  logic                          we,
    input  logic [rf_pkg::RF_ADDR_W-1:0]  waddr,
    input  logic [rf_pkg::RF_DATA_W-1:0]  wdata,
    input  logic                          re,
    input  logic [rf_pkg::RF_ADDR_W-1:0]  raddr,
    output logic [rf_pkg::RF_DATA_W-1:0]  rdata,
    output logic                          pwr_good
);

    logic reset_meta;
    logic reset_sync;
    logic isol_en;
    logic pwr_enable_b;
    logic we_gated;
    logic re_gated;

    // --------------------------------------------------
    // Two-flop reset synchronizer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            reset_meta <= 1'b1;
            reset_sync <= 1'b1;
        end else begin
            reset_meta <= 1'b0;
            reset_sync <= reset_meta;
        end
    end

    // Accesses pass only once the sequencer reports power-good
    assign we_gated = we & pwr_good;
    assign re_gated = re & pwr_good;

    rf_power_seq u_power_seq (
        .clk          (clk),
        .reset_sync   (reset_sync),
        .pwr_req      (pwr_req),
        .pwr_enable_b (pwr_enable_b),
        .isol_en      (isol_en),
        .pwr_good     (pwr_good)
    );

    rf_array u_array (
        .clk          (clk),
        .reset_sync   (reset_sync),
        .we           (we_gated),
        .waddr        (waddr),
        .wdata        (wdata),
        .re           (re_gated),
        .raddr        (raddr),
        .isol_en      (isol_en),
        .pwr_enable_b (pwr_enable_b),
        .rdata        (rdata)
    );

endmodule

/* src/rf_apb_ctrl.sv */
`timescale 1ns/1ns
/*
 * APB slave for the register file subsystem
 * Register map, staged data halves and the entry command FSM
 */
module rf_apb_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [rf_pkg::APB_ADDR_W-1:0]  paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [rf_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [rf_pkg::APB_DATA_W-1:0]  prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           pwr_req,
    output logic                           we,
    output logic [rf_pkg::RF_ADDR_W-1:0]   waddr,
    output logic [rf_pkg::RF_DATA_W-1:0]   wdata,
    output logic                           re,
    output logic [rf_pkg::RF_ADDR_W-1:0]   raddr,
    input  logic [rf_pkg::RF_DATA_W-1:0]   rdata,
    input  logic                           pwr_good
);
    import rf_pkg::*;

    logic [1:0]            state;
    logic [RF_ADDR_W-1:0]  index_q;
    logic [APB_DATA_W-1:0] wdata_lo_q;
    logic [HI_W-1:0]       wdata_hi_q;
    logic [APB_DATA_W-1:0] rdata_lo_q;
    logic [HI_W-1:0]       rdata_hi_q;
    logic                  access;
    logic                  mapped;
    logic                  cmd_mem;
    logic                  start;
    logic                  reg_wr;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    assign access = psel && penable;
    assign mapped = paddr inside {REG_CTRL, REG_STATUS, REG_INDEX, REG_WDATA_LO,
                                  REG_WDATA_HI, REG_CMD, REG_RDATA_LO, REG_RDATA_HI};

    // A known command code written to the command register
    assign cmd_mem = access && pwrite && (paddr == REG_CMD) &&
                     (pwdata == CMD_WRITE || pwdata == CMD_READ);
    // Memory commands only start with the array powered
    assign start   = (state == ST_IDLE) && cmd_mem && pwr_good;
    assign reg_wr  = access && pwrite && (state == ST_IDLE);

    // Memory pulses come straight out of the first access cycle
    assign we    = start && (pwdata == CMD_WRITE);
    assign re    = start && (pwdata == CMD_READ);
    assign waddr = index_q;
    assign raddr = index_q;
    assign wdata = {wdata_hi_q, wdata_lo_q};

    // Writes finish from WAIT2, reads pass WAIT1 first
    assign pready  = (state == ST_WAIT2) || ((state == ST_IDLE) && !start);
    // Errors only show in a zero-wait completion
    assign pslverr = access && (state == ST_IDLE) && !start && (!mapped || cmd_mem);

    // --------------------------------------------------
    // Command FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (we) begin
                        state <= ST_WAIT2;
                    end else if (re) begin
                        state <= ST_WAIT1;
                    end
                end
                ST_WAIT1: state <= ST_WAIT2;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pwr_req    <= 1'b0;
            index_q    <= '0;
            wdata_lo_q <= '0;
            wdata_hi_q <= '0;
            rdata_lo_q <= '0;
            rdata_hi_q <= '0;
        end else begin
            if (reg_wr) begin
                case (paddr)
                    REG_CTRL:     pwr_req    <= pwdata[0];
                    REG_INDEX:    index_q    <= pwdata[RF_ADDR_W-1:0];
                    REG_WDATA_LO: wdata_lo_q <= pwdata;
                    REG_WDATA_HI: wdata_hi_q <= pwdata[HI_W-1:0];
                    default: ;
                endcase
            end
            // Array data is valid in WAIT1 and lands just as pready rises
            if (state == ST_WAIT1) begin
                rdata_lo_q <= rdata[APB_DATA_W-1:0];
                rdata_hi_q <= rdata[RF_DATA_W-1:APB_DATA_W];
            end
        end
    end

    // Read mux, the command register reads as zero
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                REG_CTRL:     prdata = {{(APB_DATA_W-1){1'b0}}, pwr_req};
                REG_STATUS:   prdata = {{(APB_DATA_W-1){1'b0}}, pwr_good};
                REG_INDEX:    prdata = {{(APB_DATA_W-RF_ADDR_W){1'b0}}, index_q};
                REG_WDATA_LO: prdata = wdata_lo_q;
                REG_WDATA_HI: prdata = {{(APB_DATA_W-HI_W){1'b0}}, wdata_hi_q};
                REG_RDATA_LO: prdata = rdata_lo_q;
                REG_RDATA_HI: prdata = {{(APB_DATA_W-HI_W){1'b0}}, rdata_hi_q};
                default:      prdata = '0;
            endcase
        end
    end

    // The master never raises penable outside a selected transfer
    assert property (@(posedge clk) disable iff (reset) penable |-> psel);

    // An entry write completes one cycle after its strobe
    assert property (@(posedge clk) disable iff (reset) we |=> pready);

    // An entry read holds the bus one more cycle for the registered array data
    assert property (@(posedge clk) disable iff (reset) re |=> !pready ##1 pready);

endmodule

/* src/rf_subsys_top.sv */
`timescale 1ns/1ns
/*
 * Register file subsystem top level
 * APB controller in front of the power-gated memory wrapper
 */
module rf_subsys_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [rf_pkg::APB_ADDR_W-1:0]  paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [rf_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [rf_pkg::APB_DATA_W-1:0]  prdata,
    output logic                           pready,
    output logic                           pslverr
);
    import rf_pkg::*;

    // Controller to memory wrapper
    logic                 pwr_req;
    logic                 we;
    logic [RF_ADDR_W-1:0] waddr;
    logic [RF_DATA_W-1:0] wdata;
    logic                 re;
    logic [RF_ADDR_W-1:0] raddr;
    // Memory wrapper back to controller
    logic [RF_DATA_W-1:0] rdata;
    logic                 pwr_good;

    rf_apb_ctrl u_apb_ctrl (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .pwr_req  (pwr_req),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata),
        .re       (re),
        .raddr    (raddr),
        .rdata    (rdata),
        .pwr_good (pwr_good)
    );

    rf_pg_wrapper u_pg_wrapper (
        .clk      (clk),
        .reset    (reset),
        .pwr_req  (pwr_req),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata),
        .re       (re),
        .raddr    (raddr),
        .rdata    (rdata),
        .pwr_good (pwr_good)
    );

endmodule

/* dv/rf_subsys_tb.sv */
`timescale 1ns/1ns
/*
 * Self-checking testbench for the register file subsystem
 * Random entry traffic over APB against an entry model with a power flag
 */
module rf_subsys_tb;
    import rf_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS      = 1000;
    // Budget of 2000 bus operations at 10 cycles each, plus reset
    localparam int WATCHDOG_NS  = (2 * NUM_OPS * 10 + RESET_CYCLES) * CLK_PERIOD;

    logic                  clk;
    logic                  reset;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // Entry model, power-down drops every valid bit
    logic [RF_DATA_W-1:0] model_mem [RF_DEPTH];
    logic                 model_valid [RF_DEPTH];
    int                   seed;
    // Wait states seen in the most recent transfer
    int                   wait_states;

    rf_subsys_top dut (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $fatal(1, "simulation timeout");
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input logic [APB_DATA_W-1:0] exp,
                              input logic [APB_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "register data mismatch");
        end
    endtask

    task automatic check_entry(input string name, input logic [RF_DATA_W-1:0] exp,
                               input logic [RF_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "entry data mismatch");
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected pslverr %b, actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "bus response mismatch");
        end
    endtask

    task automatic check_waits(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERROR %s: expected %0d wait states, actual %0d", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "bus latency mismatch");
        end
    endtask

    // --------------------------------------------------
    // APB transfers
    // --------------------------------------------------
    // Called 5 ns after a rising edge and returns at the same point of a later cycle
    task automatic apb_xfer(input logic [APB_ADDR_W-1:0] addr, input logic wr,
                            input logic [APB_DATA_W-1:0] data,
                            output logic [APB_DATA_W-1:0] rd, output logic err);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #5;
        penable = 1'b1;
        wait_states = 0;
        // Responses are sampled mid-cycle, well away from the clock edge
        @(negedge clk);
        while (!pready) begin
            wait_states++;
            @(negedge clk);
        end
        rd  = prdata;
        err = pslverr;
        @(posedge clk);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data, output logic err);
        logic [APB_DATA_W-1:0] unused_rd;
        apb_xfer(addr, 1'b1, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                            output logic [APB_DATA_W-1:0] data, output logic err);
        apb_xfer(addr, 1'b0, '0, data, err);
    endtask

    // --------------------------------------------------
    // Entry and power operations
    // --------------------------------------------------
    task automatic entry_write(input logic [RF_ADDR_W-1:0] idx,
                               input logic [RF_DATA_W-1:0] data);
        logic err;
        apb_write(REG_WDATA_LO, data[APB_DATA_W-1:0], err);
        apb_write(REG_WDATA_HI, {{(APB_DATA_W-HI_W){1'b0}}, data[RF_DATA_W-1:APB_DATA_W]}, err);
        apb_write(REG_INDEX, {{(APB_DATA_W-RF_ADDR_W){1'b0}}, idx}, err);
        apb_write(REG_CMD, CMD_WRITE, err);
        check_err("entry write command", 1'b0, err);
        // One wait state covers the single write strobe
        check_waits("entry write command", 1, wait_states);
        model_mem[idx]   = data;
        model_valid[idx] = 1'b1;
    endtask

    task automatic entry_read(input logic [RF_ADDR_W-1:0] idx);
        logic                  err;
        logic [APB_DATA_W-1:0] lo;
        logic [APB_DATA_W-1:0] hi;
        logic [RF_DATA_W-1:0]  exp;
        apb_write(REG_INDEX, {{(APB_DATA_W-RF_ADDR_W){1'b0}}, idx}, err);
        apb_write(REG_CMD, CMD_READ, err);
        check_err("entry read command", 1'b0, err);
        // Strobe cycle plus the registered array output
        check_waits("entry read command", 2, wait_states);
        apb_read(REG_RDATA_LO, lo, err);
        check_waits("read data low half", 0, wait_states);
        apb_read(REG_RDATA_HI, hi, err);
        // Never-written and power-cycled entries come back as zero
        exp = model_valid[idx] ? model_mem[idx] : '0;
        check_entry($sformatf("entry read idx %0d", idx), exp, {hi[HI_W-1:0], lo});
    endtask

    task automatic power_up();
        logic                  err;
        logic [APB_DATA_W-1:0] status;
        int                    polls;
        apb_write(REG_CTRL, 32'd1, err);
        polls  = 0;
        status = '0;
        while (!status[0] && polls < 4 * PG_STAGES) begin
            apb_read(REG_STATUS, status, err);
            polls++;
        end
        if (!status[0]) begin
            $display("Power-good never rose after %0d status polls", polls);
            $display("Testbench failed");
            $fatal(1, "power-up did not complete");
        end
    endtask

    task automatic power_down();
        logic                  err;
        logic [APB_DATA_W-1:0] status;
        apb_write(REG_CTRL, 32'd0, err);
        for (int i = 0; i < RF_DEPTH; i++) begin
            model_valid[i] = 1'b0;
        end
        apb_read(REG_STATUS, status, err);
        check_word("status after power-down", 32'd0, status);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        logic                  err;
        logic [APB_DATA_W-1:0] rd;
        logic [31:0]           r1;
        logic [31:0]           r2;
        logic [31:0]           r3;

        seed        = 32'h4ccaf3df;
        wait_states = 0;
        reset       = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        for (int i = 0; i < RF_DEPTH; i++) begin
            model_mem[i]   = '0;
            model_valid[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset = 1'b0;

        // Idle state after reset, commands are refused without power
        apb_read(REG_STATUS, rd, err);
        check_word("status after reset", 32'd0, rd);
        apb_write(REG_CMD, CMD_READ, err);
        check_err("read command while unpowered", 1'b1, err);
        check_waits("read command while unpowered", 0, wait_states);
        apb_write(REG_CMD, CMD_WRITE, err);
        check_err("write command while unpowered", 1'b1, err);
        check_waits("write command while unpowered", 0, wait_states);

        power_up();

        for (int op = 0; op < NUM_OPS; op++) begin
            if (op == NUM_OPS / 2) begin
                power_down();
                apb_write(REG_CMD, CMD_READ, err);
                check_err("read command after power-down", 1'b1, err);
                power_up();
                // Contents were lost, the whole array must read zero
                for (int i = 0; i < RF_DEPTH; i++) begin
                    entry_read(i[RF_ADDR_W-1:0]);
                end
            end
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            if (r1[8]) begin
                entry_write(r1[RF_ADDR_W-1:0], {r2[HI_W-1:0], r3});
            end else begin
                entry_read(r1[RF_ADDR_W-1:0]);
            end
        end

        // Error responses and read-only status
        apb_read(8'h20, rd, err);
        check_err("read of unmapped offset", 1'b1, err);
        apb_write(8'h20, 32'hffff_ffff, err);
        check_err("write to unmapped offset", 1'b1, err);
        apb_write(REG_STATUS, 32'd0, err);
        check_err("write to status", 1'b0, err);
        apb_read(REG_STATUS, rd, err);
        check_word("status after write", 32'd1, rd);
        apb_write(REG_CMD, 32'd7, err);
        check_err("unknown command code", 1'b0, err);
        check_waits("unknown command code", 0, wait_states);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* list.f */
src/rf_pkg.sv
src/rf_array.sv
src/rf_power_seq.sv
src/rf_pg_wrapper.sv
src/rf_apb_ctrl.sv
src/rf_subsys_top.sv
dv/rf_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rf_subsys_tb \
    -Mdir obj_dir -o rf_sim > build.log 2>&1 \
    && ./obj_dir/rf_sim > sim.log 2>&1 \
    && grep -q "Testbench passed" sim.log \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL, see build.log and sim.log"; exit 1; }
